// File: verilog/exe_op_pkg.sv
package exe_op_pkg;

    // one code per operation, numbered in the order of the old one-hot bus
    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_SLT   = 5'd2,
        OP_SLTU  = 5'd3,
        OP_AND   = 5'd4,
        OP_NOR   = 5'd5,
        OP_OR    = 5'd6,
        OP_XOR   = 5'd7,
        OP_SLL   = 5'd8,
        OP_SRL   = 5'd9,
        OP_SRA   = 5'd10,
        OP_LUI   = 5'd11,
        OP_MUL   = 5'd12,  // low product word
        OP_MULH  = 5'd13,  // high word, signed
        OP_MULHU = 5'd14,  // high word, unsigned
        OP_DIV   = 5'd15,
        OP_DIVU  = 5'd16,
        OP_MOD   = 5'd17,
        OP_MODU  = 5'd18
    } alu_op_e;

    // multiplier ops, result taken from the product
    function automatic logic op_is_mul(input alu_op_e op);
        return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHU);
    endfunction

    // divider ops, long latency
    function automatic logic op_is_div(input alu_op_e op);
        return (op == OP_DIV) || (op == OP_DIVU) || (op == OP_MOD) || (op == OP_MODU);
    endfunction

endpackage

// File: verilog/exe_data_pkg.sv
package exe_data_pkg;

    typedef logic [31:0] word_t;   // operand or result
    typedef logic [63:0] dword_t;  // full product
    typedef logic [4:0]  shamt_t;  // shift amount, low bits of src2

    // request into the execute unit
    typedef struct packed {
        exe_op_pkg::alu_op_e op;
        word_t               src1;
        word_t               src2;
    } exe_req_t;

    // divider output, both results of one divide
    typedef struct packed {
        word_t quot;
        word_t rem;
    } div_res_t;

endpackage

// File: verilog/mul_unit.sv
module mul_unit (
    input  logic                 clk,
    input  exe_data_pkg::word_t  src1,
    input  exe_data_pkg::word_t  src2,
    input  logic                 mul_signed,
    output exe_data_pkg::dword_t product
);
    import exe_data_pkg::*;

    logic [32:0]        a_ext;
    logic [32:0]        b_ext;
    logic signed [16:0] a_hi;
    logic signed [16:0] b_hi;
    logic [15:0]        a_lo;
    logic [15:0]        b_lo;

    logic [31:0]        pp_ll;  // stage 1 partial products
    logic signed [33:0] pp_lh;
    logic signed [33:0] pp_hl;
    logic signed [33:0] pp_hh;
    dword_t             pp_sum;

    assign a_ext = {mul_signed & src1[31], src1};
    assign b_ext = {mul_signed & src2[31], src2};
    assign a_hi  = a_ext[32:16];  // signed upper half
    assign b_hi  = b_ext[32:16];
    assign a_lo  = a_ext[15:0];   // unsigned lower half
    assign b_lo  = b_ext[15:0];

    always_ff @(posedge clk) begin
        pp_ll <= a_lo * b_lo;
        pp_lh <= $signed({1'b0, a_lo}) * b_hi;
        pp_hl <= a_hi * $signed({1'b0, b_lo});
        pp_hh <= a_hi * b_hi;
    end

    // sign-extend and align, wraps to 64 bits
    assign pp_sum = {32'b0, pp_ll}
                  + ({{30{pp_lh[33]}}, pp_lh} << 16)
                  + ({{30{pp_hl[33]}}, pp_hl} << 16)
                  + ({{30{pp_hh[33]}}, pp_hh} << 32);

    always_ff @(posedge clk) begin
        product <= pp_sum;
    end

endmodule

// File: verilog/div_unit.sv
module div_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   div_signed,
    input  exe_data_pkg::word_t    dividend,
    input  exe_data_pkg::word_t    divisor,
    output logic                   busy,
    output logic                   done,
    output exe_data_pkg::div_res_t res
);
    import exe_data_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_e;

    div_state_e  state;
    logic [4:0]  step_cnt;     // iteration index, 32 steps
    word_t       rem_q;        // partial remainder
    word_t       quot_q;       // dividend bits in, quotient bits out
    word_t       divisor_q;
    logic        neg_quot;
    logic        neg_rem;
    word_t       dividend_mag;
    word_t       divisor_mag;
    logic [32:0] shifted;
    logic [33:0] trial;

    assign dividend_mag = (div_signed && dividend[31]) ? -dividend : dividend;
    assign divisor_mag  = (div_signed && divisor[31])  ? -divisor  : divisor;

    // restoring step, next dividend bit into the remainder
    assign shifted = {rem_q, quot_q[31]};
    assign trial   = {1'b0, shifted} - {2'b00, divisor_q};

    assign busy = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= (state == FIX);  // result registered in FIX
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end
                end
                RUN: begin
                    step_cnt <= step_cnt + 5'd1;
                    if (step_cnt == 5'd31) begin
                        state <= FIX;
                    end
                end
                FIX: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            rem_q     <= '0;
            quot_q    <= dividend_mag;
            divisor_q <= divisor_mag;
            // zero divisor keeps the all-ones quotient
            neg_quot  <= div_signed & (dividend[31] ^ divisor[31]) & (|divisor);
            neg_rem   <= div_signed & dividend[31];
        end else if (state == RUN) begin
            if (!trial[33]) begin
                rem_q  <= trial[31:0];
                quot_q <= {quot_q[30:0], 1'b1};
            end else begin
                rem_q  <= shifted[31:0];
                quot_q <= {quot_q[30:0], 1'b0};
            end
        end else if (state == FIX) begin
            res.quot <= neg_quot ? -quot_q : quot_q;
            res.rem  <= neg_rem  ? -rem_q  : rem_q;  // remainder follows dividend sign
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("div_unit: start while busy");

    a_done_latency: assert property (@(posedge clk) disable iff (rst) start |-> ##34 done)
        else $error("div_unit: done not 34 cycles after start");

endmodule

// File: verilog/alu_core.sv
module alu_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  exe_data_pkg::exe_req_t req,
    output exe_data_pkg::word_t    mul_src1,
    output exe_data_pkg::word_t    mul_src2,
    output logic                   mul_signed,
    input  exe_data_pkg::dword_t   product,
    output logic                   div_start,
    output logic                   div_signed,
    output exe_data_pkg::word_t    div_dividend,
    output exe_data_pkg::word_t    div_divisor,
    input  logic                   div_busy,
    input  logic                   div_done,
    input  exe_data_pkg::div_res_t div_res,
    output logic                   busy,
    output logic                   result_valid,
    output exe_data_pkg::word_t    result
);
    import exe_op_pkg::*;
    import exe_data_pkg::*;

    logic   use_sub;      // sub, slt and sltu share the adder
    word_t  adder_b;
    word_t  adder_sum;
    logic   adder_cout;
    shamt_t shamt;
    dword_t sr64;
    word_t  alu_res;

    logic   s1_valid;
    logic   s1_mul;
    logic   s1_hi;
    word_t  s1_res;
    logic   s2_valid;
    logic   s2_mul;
    logic   s2_hi;
    word_t  s2_res;
    word_t  s2_word;
    logic   rem_sel;      // mod/modu return the remainder

    assign use_sub = (req.op == OP_SUB) || (req.op == OP_SLT) || (req.op == OP_SLTU);
    assign adder_b = use_sub ? ~req.src2 : req.src2;
    assign {adder_cout, adder_sum} = {1'b0, req.src1} + {1'b0, adder_b} + {32'b0, use_sub};

    assign shamt = req.src2[4:0];
    assign sr64  = {{32{(req.op == OP_SRA) & req.src1[31]}}, req.src1} >> shamt;

    always_comb begin
        case (req.op)
            OP_ADD, OP_SUB: alu_res = adder_sum;
            OP_SLT:  alu_res = {31'b0, (req.src1[31] & ~req.src2[31])
                                     | (~(req.src1[31] ^ req.src2[31]) & adder_sum[31])};
            OP_SLTU: alu_res = {31'b0, ~adder_cout};  // borrow out
            OP_AND:  alu_res = req.src1 & req.src2;
            OP_NOR:  alu_res = ~(req.src1 | req.src2);
            OP_OR:   alu_res = req.src1 | req.src2;
            OP_XOR:  alu_res = req.src1 ^ req.src2;
            OP_SLL:  alu_res = req.src1 << shamt;
            OP_SRL, OP_SRA: alu_res = sr64[31:0];
            OP_LUI:  alu_res = req.src2;  // immediate already placed upstream
            default: alu_res = '0;
        endcase
    end

    // multiplier sees every request, result picked up two cycles later
    assign mul_src1   = req.src1;
    assign mul_src2   = req.src2;
    assign mul_signed = (req.op == OP_MULH);

    assign div_start    = req_valid & op_is_div(req.op);
    assign div_signed   = (req.op == OP_DIV) || (req.op == OP_MOD);
    assign div_dividend = req.src1;
    assign div_divisor  = req.src2;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid & ~op_is_div(req.op);
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_mul <= op_is_mul(req.op);
        s1_hi  <= (req.op == OP_MULH) || (req.op == OP_MULHU);
        s1_res <= alu_res;
        s2_mul <= s1_mul;
        s2_hi  <= s1_hi;
        s2_res <= s1_res;
        if (div_start) begin
            rem_sel <= (req.op == OP_MOD) || (req.op == OP_MODU);
        end
    end

    assign s2_word = !s2_mul ? s2_res
                   : (s2_hi ? product[63:32] : product[31:0]);

    assign busy         = div_busy;
    assign result_valid = s2_valid | div_done;
    assign result       = div_done ? (rem_sel ? div_res.rem : div_res.quot) : s2_word;

    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst) req_valid |-> !div_busy)
        else $error("alu_core: request issued while divider busy");

    // divide result and a pipelined result must never share the output
    a_no_collide: assert property (@(posedge clk) disable iff (rst) div_done |-> !s2_valid)
        else $error("alu_core: divider done collides with pipeline result");

endmodule

// File: verilog/exe_unit.sv
module exe_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  exe_data_pkg::exe_req_t req,
    output logic                   busy,
    output logic                   result_valid,
    output exe_data_pkg::word_t    result
);
    import exe_data_pkg::*;

    word_t    mul_src1;
    word_t    mul_src2;
    logic     mul_signed;
    dword_t   product;
    logic     div_start;
    logic     div_signed;
    word_t    div_dividend;
    word_t    div_divisor;
    logic     div_busy;
    logic     div_done;
    div_res_t div_res;

    alu_core u_alu_core (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .mul_src1     (mul_src1),
        .mul_src2     (mul_src2),
        .mul_signed   (mul_signed),
        .product      (product),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_busy     (div_busy),
        .div_done     (div_done),
        .div_res      (div_res),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    mul_unit u_mul_unit (
        .clk        (clk),
        .src1       (mul_src1),
        .src2       (mul_src2),
        .mul_signed (mul_signed),
        .product    (product)
    );

    div_unit u_div_unit (
        .clk        (clk),
        .rst        (rst),
        .start      (div_start),
        .div_signed (div_signed),
        .dividend   (div_dividend),
        .divisor    (div_divisor),
        .busy       (div_busy),
        .done       (div_done),
        .res        (div_res)
    );

endmodule

// File: bench/tb_exe_unit.sv
module tb_exe_unit;
    timeunit 1ns;
    timeprecision 100ps;
    import exe_op_pkg::*;
    import exe_data_pkg::*;

    logic     clk = 1'b0;
    logic     rst;
    logic     req_valid;
    exe_req_t req;
    logic     busy;
    logic     result_valid;
    word_t    result;

    int    cyc = 0;           // rising edges so far
    int    chk_errors = 0;
    int    mon_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    word_t exp_val[4096];     // expected results in issue order
    int    exp_due[4096];     // cycle in which each result is due
    int    tail = 0;          // written by the stimulus side
    int    head = 0;          // advanced by the monitor
    int    div_due = -1;      // completion cycle of the last divide
    word_t corner[6] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h1f};
    word_t div_a[6]  = '{32'd100, 32'h8000_0000, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
                         32'h8000_0001};
    word_t div_b[6]  = '{32'd0, 32'hffff_ffff, 32'd2, 32'hffff_fffe, 32'hffff_fffe, 32'd0};

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    exe_unit DUT (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    function automatic word_t model(input alu_op_e op, input word_t a, input word_t b);
        logic signed [63:0] sp;
        logic [63:0]        up;
        word_t              q;
        word_t              r;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'b0, a} * {32'b0, b};
        if (b == 32'h0) begin
            q = 32'hffff_ffff;  // divide by zero
            r = a;
        end else if (op == OP_DIV || op == OP_MOD) begin
            if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
                q = 32'h8000_0000;
                r = 32'h0;
            end else begin
                q = $signed(a) / $signed(b);  // truncates toward zero
                r = $signed(a) % $signed(b);
            end
        end else begin
            q = a / b;
            r = a % b;
        end
        case (op)
            OP_ADD:          return a + b;
            OP_SUB:          return a - b;
            OP_SLT:          return {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:         return {31'b0, a < b};
            OP_AND:          return a & b;
            OP_NOR:          return ~(a | b);
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLL:          return a << b[4:0];
            OP_SRL:          return a >> b[4:0];
            OP_SRA:          return $signed(a) >>> b[4:0];
            OP_LUI:          return b;
            OP_MUL:          return sp[31:0];
            OP_MULH:         return sp[63:32];
            OP_MULHU:        return up[63:32];
            OP_DIV, OP_DIVU: return q;
            default:         return r;
        endcase
    endfunction

    // result checker, sampled mid-cycle
    always @(negedge clk) begin
        logic exp_busy;
        if (!rst) begin
            exp_busy = (cyc >= div_due - 33) && (cyc < div_due);
            assert (busy == exp_busy) else begin
                $display("Error at %0t: busy expected %b got %b", $time, exp_busy, busy);
                mon_errors++;
            end
            if (result_valid) begin
                assert (head < tail) else begin
                    $display("result_valid rose at %0t with no request outstanding", $time);
                    mon_errors++;
                end
                if (head < tail) begin
                    assert (cyc == exp_due[head]) else begin
                        $display("Error at %0t: result_valid cycle expected %0d got %0d",
                                 $time, exp_due[head], cyc);
                        mon_errors++;
                    end
                    assert (result == exp_val[head]) else begin
                        $display("Error at %0t: result expected %h got %h",
                                 $time, exp_val[head], result);
                        mon_errors++;
                    end
                    head++;
                end
            end else if (head < tail) begin
                assert (cyc <= exp_due[head]) else begin
                    $display("result due in cycle %0d never arrived", exp_due[head]);
                    mon_errors++;
                    head++;
                end
            end
        end
    end

    task automatic issue(input alu_op_e op, input word_t a, input word_t b);
        int lat;
        lat = (op >= OP_DIV) ? 34 : 2;
        @(posedge clk);
        #1;
        req_valid = 1'b1;
        req.op    = op;
        req.src1  = a;
        req.src2  = b;
        exp_val[tail] = model(op, a, b);
        exp_due[tail] = cyc + lat;
        tail++;
        if (lat == 34) div_due = cyc + lat;
    endtask

    task automatic drain();
        int waited;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        waited = 0;
        while (head < tail && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        if (head < tail) begin
            $display("Timeout at %0t: %0d results never arrived", $time, tail - head);
            chk_errors++;
            head = tail;  // drop the lost results
        end
    endtask

    task automatic report(input string name, input int err_before);
        int err_now;
        err_now = chk_errors + mon_errors;
        tests_run++;
        if (err_now != err_before) tests_failed++;
        $display("test %-12s %s, %0d errors", name,
                 (err_now == err_before) ? "passed" : "failed", err_now - err_before);
    endtask

    task automatic alu_ops();
        int e0;
        alu_op_e op;
        e0 = chk_errors + mon_errors;
        assert (!busy && !result_valid) else begin
            $display("busy or result_valid is high right after reset");
            chk_errors++;
        end
        for (int o = 0; o < 12; o++) begin
            op = alu_op_e'(5'(o));
            for (int i = 0; i < 36; i++) begin
                issue(op, corner[i / 6], corner[i % 6]);
                drain();
            end
            for (int i = 0; i < 50; i++) begin
                issue(op, $urandom, $urandom);
                drain();
            end
        end
        report("alu", e0);
    endtask

    task automatic stream_mixed();
        int e0;
        e0 = chk_errors + mon_errors;
        for (int i = 0; i < 40; i++) begin
            issue(alu_op_e'(5'($urandom % 15)), $urandom, $urandom);  // one per cycle
        end
        drain();
        report("stream", e0);
    endtask

    task automatic multiply_ops();
        int e0;
        alu_op_e op;
        e0 = chk_errors + mon_errors;
        for (int o = 12; o < 15; o++) begin
            op = alu_op_e'(5'(o));
            for (int i = 0; i < 36; i++) begin
                issue(op, corner[i / 6], corner[i % 6]);
            end
            for (int i = 0; i < 20; i++) begin
                issue(op, $urandom, $urandom);
            end
        end
        drain();
        report("multiply", e0);
    endtask

    task automatic random_divide();
        int e0;
        e0 = chk_errors + mon_errors;
        for (int o = 15; o < 19; o++) begin
            for (int i = 0; i < 5; i++) begin
                issue(alu_op_e'(5'(o)), $urandom, $urandom >> ($urandom % 32));
                drain();
            end
        end
        report("divide", e0);
    endtask

    task automatic divide_corners();
        int e0;
        e0 = chk_errors + mon_errors;
        for (int o = 15; o < 19; o++) begin
            for (int i = 0; i < 6; i++) begin
                issue(alu_op_e'(5'(o)), div_a[i], div_b[i]);
                drain();
            end
        end
        report("div_corner", e0);
    endtask

    task automatic overlap_mul_div();
        int e0;
        e0 = chk_errors + mon_errors;
        issue(OP_MUL, $urandom, $urandom);  // returns before the divide
        issue(OP_DIV, $urandom, $urandom >> 8);
        drain();
        issue(OP_MULHU, $urandom, $urandom);
        issue(OP_MODU, $urandom, $urandom >> 4);
        drain();
        report("overlap", e0);
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        void'($urandom(37607));
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        alu_ops();
        stream_mixed();
        multiply_ops();
        random_divide();
        divide_corners();
        overlap_mul_div();
        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, chk_errors + mon_errors);
        if (chk_errors + mon_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: exe.f
verilog/exe_op_pkg.sv
verilog/exe_data_pkg.sv
verilog/mul_unit.sv
verilog/div_unit.sv
verilog/alu_core.sv
verilog/exe_unit.sv
bench/tb_exe_unit.sv

// File: Makefile
TOP = tb_exe_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f exe.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "STATUS: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
